/* hw/sram_fifo_pkg.sv */
// sram fifo shared definitions: version, sram geometry, register map, input word layout
`default_nettype none

package sram_fifo_pkg;

    localparam logic [7:0] VERSION = 8'd2;

    localparam int SRAM_ADDR_W = 20;
    localparam int SRAM_DATA_W = 16;

    // apb register map
    localparam logic [3:0] REG_CTRL  = 4'd0;  // read version, write soft reset
    localparam logic [3:0] REG_AF    = 4'd1;
    localparam logic [3:0] REG_AE    = 4'd2;
    localparam logic [3:0] REG_ERR   = 4'd3;
    localparam logic [3:0] REG_SIZE0 = 4'd4;  // live low byte, takes snapshot
    localparam logic [3:0] REG_SIZE1 = 4'd5;
    localparam logic [3:0] REG_SIZE2 = 4'd6;

    // producer word, split into two sram half-words with half[0] the low one
    typedef union packed {
        logic [31:0]                        word;
        logic [1:0][SRAM_DATA_W-1:0]        half;
    } data_word_u;

endpackage

`default_nettype wire

/* hw/sram_fifo_regs.sv */
// sram fifo apb registers: soft reset, thresholds, read error counter and size snapshot
`timescale 1ns/1ps
`default_nettype none

module sram_fifo_regs
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH      = 64,
    parameter int AF_PERCENT = 95,
    parameter int AE_PERCENT = 5
) (
    input  wire                         BUS_CLK,
    input  wire                         RST,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire  [3:0]                  paddr,
    input  wire  [7:0]                  pwdata,
    output logic [7:0]                  prdata,
    input  wire  [$clog2(DEPTH)-1:0]    level,
    input  wire  [1:0]                  hold_bytes,
    input  wire                         rd_err,
    output logic                        soft_rst,
    output logic [7:0]                  af_value,
    output logic [7:0]                  ae_value,
    output logic                        fifo_read_error
);

    localparam logic [7:0] AF_INIT = 8'(255 * AF_PERCENT / 100);
    localparam logic [7:0] AE_INIT = 8'(255 * AE_PERCENT / 100);

    logic           apb_wr;
    logic           apb_rd;
    logic           rst_all;
    logic [7:0]     err_cnt;
    logic [21:0]    size_bytes;
    logic [21:0]    size_snap;

    assign apb_wr  = psel && penable && pwrite;
    assign apb_rd  = psel && penable && !pwrite;
    assign rst_all = RST || soft_rst;

    // half-words in sram plus bytes still held for output
    assign size_bytes = 22'({level, 1'b0}) + 22'(hold_bytes);

    assign fifo_read_error = (err_cnt != 8'd0);

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= apb_wr && (paddr == REG_CTRL);  // one cycle pulse
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (rst_all) begin
            af_value <= AF_INIT;
            ae_value <= AE_INIT;
        end else if (apb_wr) begin
            if (paddr == REG_AF) begin
                af_value <= pwdata;
            end
            if (paddr == REG_AE) begin
                ae_value <= pwdata;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (rst_all) begin
            err_cnt <= 8'd0;
        end else if (rd_err && err_cnt != 8'hff) begin
            err_cnt <= err_cnt + 8'd1;  // saturates
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (apb_rd && paddr == REG_SIZE0) begin
            size_snap <= size_bytes;
        end
    end

    always_comb begin
        case (paddr)
            REG_CTRL:  prdata = VERSION;
            REG_AF:    prdata = af_value;
            REG_AE:    prdata = ae_value;
            REG_ERR:   prdata = err_cnt;
            REG_SIZE0: prdata = size_bytes[7:0];  // live, snapshot taken alongside
            REG_SIZE1: prdata = size_snap[15:8];
            REG_SIZE2: prdata = {2'b00, size_snap[21:16]};
            default:   prdata = 8'd0;
        endcase
    end

endmodule

`default_nettype wire

/* hw/word_buffer.sv */
// four-entry first-word-fall-through buffer between the producer and the sram controller
`timescale 1ns/1ps
`default_nettype none

module word_buffer
    import sram_fifo_pkg::*;
(
    input  wire                 BUS_CLK,
    input  wire                 RST,
    input  wire                 in_empty,
    input  wire  [31:0]         in_data,
    output logic                in_read,
    input  wire                 buf_pop,
    output logic                buf_empty,
    output data_word_u          buf_data
);

    data_word_u     mem [4];
    logic [1:0]     wr_idx;
    logic [1:0]     rd_idx;
    logic [2:0]     count;
    logic           push;
    logic           pop;

    assign in_read   = (count != 3'd4);
    assign buf_empty = (count == 3'd0);
    assign push      = in_read && !in_empty;
    assign pop       = buf_pop && !buf_empty;
    assign buf_data  = mem[rd_idx];  // head word always presented

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_idx <= 2'd0;
            rd_idx <= 2'd0;
            count  <= 3'd0;
        end else begin
            if (push) begin
                wr_idx <= wr_idx + 2'd1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 2'd1;
            end
            if (push && !pop) begin
                count <= count + 3'd1;
            end else if (pop && !push) begin
                count <= count - 3'd1;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            mem[wr_idx].word <= in_data;
        end
    end

endmodule

`default_nettype wire

/* hw/sram_ctrl.sv */
// sram ring controller: read/write scheduling, pin drive and byte output holding register
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH = 64
) (
    input  wire                         BUS_CLK,
    input  wire                         RST,
    input  wire                         buf_empty,
    input  wire  data_word_u            buf_data,
    output logic                        buf_pop,
    output logic [SRAM_ADDR_W-1:0]      sram_a,
    inout  wire  [SRAM_DATA_W-1:0]      sram_dq,
    output logic                        sram_we_b,
    output logic                        sram_oe_b,
    input  wire                         out_ready,
    output logic                        out_valid,
    output logic [7:0]                  out_data,
    output logic [$clog2(DEPTH)-1:0]    level,
    output logic [1:0]                  hold_bytes,
    output logic                        rd_err
);

    localparam int AW = $clog2(DEPTH);

    logic [AW-1:0]          wr_ptr;
    logic [AW-1:0]          rd_ptr;
    logic                   half_sel;
    logic                   rd_go;
    logic                   wr_go;
    logic                   fire;
    logic                   hold_free;
    logic [SRAM_DATA_W-1:0] dq_out;
    logic [SRAM_DATA_W-1:0] hold_data;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        logic [AW-1:0] nxt;
        if (ptr == AW'(DEPTH - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign out_valid = (hold_bytes != 2'd0);
    assign fire      = out_valid && out_ready;
    assign rd_err    = out_ready && !out_valid;  // consumer asked with nothing to give

    // low byte first, then high byte
    assign out_data = (hold_bytes == 2'd2) ? hold_data[7:0] : hold_data[15:8];

    // holding register empty, or handing out its last byte now
    assign hold_free = (hold_bytes == 2'd0) || (hold_bytes == 2'd1 && fire);

    // a read in flight also counts as occupying the holding register
    assign rd_go = (level != '0) && sram_oe_b && hold_free;

    // writes only when no read this cycle, one slot kept free
    assign wr_go = !rd_go && !buf_empty && (level != AW'(DEPTH - 1));

    assign buf_pop = wr_go && half_sel;  // word leaves the buffer with its high half

    assign sram_dq = sram_we_b ? 'z : dq_out;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            half_sel   <= 1'b0;
            level      <= '0;
            sram_we_b  <= 1'b1;
            sram_oe_b  <= 1'b1;
            hold_bytes <= 2'd0;
        end else begin
            sram_we_b <= !wr_go;
            sram_oe_b <= !rd_go;
            if (wr_go) begin
                wr_ptr   <= ptr_inc(wr_ptr);
                half_sel <= !half_sel;
                level    <= level + 1'b1;
            end else if (rd_go) begin
                rd_ptr <= ptr_inc(rd_ptr);
                level  <= level - 1'b1;
            end
            if (!sram_oe_b) begin
                hold_bytes <= 2'd2;  // read data lands at the end of the read cycle
            end else if (fire) begin
                hold_bytes <= hold_bytes - 2'd1;
            end
        end
    end

    // address and write data only change when a new access is issued
    always_ff @(posedge BUS_CLK) begin
        if (rd_go) begin
            sram_a <= SRAM_ADDR_W'(rd_ptr);
        end else if (wr_go) begin
            sram_a <= SRAM_ADDR_W'(wr_ptr);
            dq_out <= buf_data.half[half_sel];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (!sram_oe_b) begin
            hold_data <= sram_dq;
        end
    end

endmodule

`default_nettype wire

/* hw/fill_monitor.sv */
// fill level monitor: near-full flag with hysteresis, full and not-empty flags
`timescale 1ns/1ps
`default_nettype none

module fill_monitor #(
    parameter int DEPTH = 64
) (
    input  wire                         BUS_CLK,
    input  wire                         RST,
    input  wire  [$clog2(DEPTH)-1:0]    level,
    input  wire  [7:0]                  af_value,
    input  wire  [7:0]                  ae_value,
    output logic                        near_full,
    output logic                        fifo_full,
    output logic                        fifo_not_empty
);

    localparam int AW = $clog2(DEPTH);
    localparam int TW = AW + 9;

    logic [TW-1:0] af_thr;
    logic [TW-1:0] ae_thr;
    logic [TW-1:0] level_ext;

    // thresholds scale the 8-bit register values to the ring size
    assign af_thr    = ((TW'(af_value) + TW'(1)) * TW'(DEPTH)) >> 8;
    assign ae_thr    = ((TW'(ae_value) + TW'(1)) * TW'(DEPTH)) >> 8;
    assign level_ext = TW'(level);

    assign fifo_full      = (level == AW'(DEPTH - 1));
    assign fifo_not_empty = (level != '0);

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            near_full <= 1'b0;
        end else if (level_ext >= af_thr || af_value == 8'd0) begin
            near_full <= 1'b1;
        end else if (level == '0 || (ae_value != 8'd0 && level_ext <= ae_thr)) begin
            near_full <= 1'b0;
        end
        // between the two thresholds the flag keeps its state
    end

endmodule

`default_nettype wire

/* hw/sram_fifo_top.sv */
// sram spill fifo top level: apb registers, input buffer, sram controller and fill monitor
`timescale 1ns/1ps
`default_nettype none

module sram_fifo_top
    import sram_fifo_pkg::*;
#(
    parameter int DEPTH      = 64,
    parameter int AF_PERCENT = 95,
    parameter int AE_PERCENT = 5
) (
    input  wire                     BUS_CLK,
    input  wire                     RST,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire  [3:0]              paddr,
    input  wire  [7:0]              pwdata,
    output wire  [7:0]              prdata,
    input  wire                     in_empty,
    input  wire  [31:0]             in_data,
    output wire                     in_read,
    output wire                     out_valid,
    output wire  [7:0]              out_data,
    input  wire                     out_ready,
    output wire  [SRAM_ADDR_W-1:0]  sram_a,
    inout  wire  [SRAM_DATA_W-1:0]  sram_dq,
    output wire                     sram_we_b,
    output wire                     sram_oe_b,
    output wire                     near_full,
    output wire                     fifo_full,
    output wire                     fifo_not_empty,
    output wire                     fifo_read_error
);

    wire                        soft_rst;
    wire                        blk_rst;
    wire [7:0]                  af_value;
    wire [7:0]                  ae_value;
    wire [$clog2(DEPTH)-1:0]    level;
    wire [1:0]                  hold_bytes;
    wire                        rd_err;
    wire                        buf_empty;
    wire                        buf_pop;
    wire data_word_u            buf_data;

    assign blk_rst = RST || soft_rst;  // soft reset clears the datapath too

    sram_fifo_regs #(
        .DEPTH      (DEPTH),
        .AF_PERCENT (AF_PERCENT),
        .AE_PERCENT (AE_PERCENT)
    ) i_regs (
        .BUS_CLK         (BUS_CLK),
        .RST             (RST),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .level           (level),
        .hold_bytes      (hold_bytes),
        .rd_err          (rd_err),
        .soft_rst        (soft_rst),
        .af_value        (af_value),
        .ae_value        (ae_value),
        .fifo_read_error (fifo_read_error)
    );

    word_buffer i_buf (
        .BUS_CLK   (BUS_CLK),
        .RST       (blk_rst),
        .in_empty  (in_empty),
        .in_data   (in_data),
        .in_read   (in_read),
        .buf_pop   (buf_pop),
        .buf_empty (buf_empty),
        .buf_data  (buf_data)
    );

    sram_ctrl #(
        .DEPTH (DEPTH)
    ) i_ctrl (
        .BUS_CLK    (BUS_CLK),
        .RST        (blk_rst),
        .buf_empty  (buf_empty),
        .buf_data   (buf_data),
        .buf_pop    (buf_pop),
        .sram_a     (sram_a),
        .sram_dq    (sram_dq),
        .sram_we_b  (sram_we_b),
        .sram_oe_b  (sram_oe_b),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .level      (level),
        .hold_bytes (hold_bytes),
        .rd_err     (rd_err)
    );

    fill_monitor #(
        .DEPTH (DEPTH)
    ) i_mon (
        .BUS_CLK        (BUS_CLK),
        .RST            (blk_rst),
        .level          (level),
        .af_value       (af_value),
        .ae_value       (ae_value),
        .near_full      (near_full),
        .fifo_full      (fifo_full),
        .fifo_not_empty (fifo_not_empty)
    );

endmodule

`default_nettype wire

/* verification/sram_model.sv */
// behavioral asynchronous 16-bit sram, a write lands when its access ends
`timescale 1ns/1ps
`default_nettype none

module sram_model #(
    parameter int ADDR_W = 20,
    parameter int DATA_W = 16,
    parameter int MEM_AW = 10
) (
    input  wire [ADDR_W-1:0]    sram_a,
    inout  wire [DATA_W-1:0]    sram_dq,
    input  wire                 sram_we_b,
    input  wire                 sram_oe_b
);

    logic [DATA_W-1:0]  mem [1 << MEM_AW];
    wire  [ADDR_W-1:0]  a_dly;
    wire  [DATA_W-1:0]  dq_dly;
    wire                we_dly;

    // delayed copies still show the access that is just ending
    assign #1 a_dly  = sram_a;
    assign #1 dq_dly = sram_dq;
    assign #1 we_dly = sram_we_b;

    assign sram_dq = (!sram_oe_b && sram_we_b) ? mem[sram_a[MEM_AW-1:0]] : {DATA_W{1'bz}};

    // any pin change closes a write, back-to-back writes included
    always @(sram_a or sram_we_b or sram_dq) begin
        if (we_dly == 1'b0) begin
            mem[a_dly[MEM_AW-1:0]] = dq_dly;
        end
    end

endmodule

`default_nettype wire

/* verification/sram_ctrl_props.sv */
// sram controller assertions: one access per cycle, no write into a full ring, output hold
`timescale 1ns/1ps
`default_nettype none

module sram_ctrl_props #(
    parameter int DEPTH = 64
) (
    input wire                      BUS_CLK,
    input wire                      RST,
    input wire                      sram_we_b,
    input wire                      sram_oe_b,
    input wire [$clog2(DEPTH)-1:0]  level,
    input wire                      out_valid,
    input wire                      out_ready,
    input wire [7:0]                out_data
);

    int fail_cnt = 0;

    a_one_access: assert property (@(posedge BUS_CLK) disable iff (RST)
        sram_we_b || sram_oe_b)
        else begin
            fail_cnt++;
            $error("sram write and read strobes low in the same cycle");
        end

    // write strobe low means the write was issued at the previous level
    a_no_full_write: assert property (@(posedge BUS_CLK) disable iff (RST)
        !sram_we_b |-> (int'($past(level)) != DEPTH - 1))
        else begin
            fail_cnt++;
            $error("sram write issued while the ring held DEPTH-1 half-words");
        end

    a_out_hold: assert property (@(posedge BUS_CLK) disable iff (RST)
        out_valid && !out_ready |=> $stable(out_data))
        else begin
            fail_cnt++;
            $error("out_data changed while waiting for out_ready");
        end

endmodule

`default_nettype wire

/* verification/tb_sram_fifo.sv */
// directed testbench for the sram spill fifo
`timescale 1ns/1ps
`default_nettype none

module tb_sram_fifo
    import sram_fifo_pkg::*;
();

    localparam int DEPTH      = 64;
    localparam int CLK_PERIOD = 100;
    localparam int AF_EXP     = 255 * 95 / 100;
    localparam int AE_EXP     = 255 * 5 / 100;
    localparam int NF_SET     = (AF_EXP + 1) * DEPTH / 256;
    localparam int NF_CLR     = (AE_EXP + 1) * DEPTH / 256;
    localparam int WATCHDOG   = ((20 + 10 + 40) * 40 + 600) * CLK_PERIOD;  // words x per-word bound

    logic                   BUS_CLK;
    logic                   RST;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [3:0]             paddr;
    logic [7:0]             pwdata;
    wire  [7:0]             prdata;
    logic                   in_empty;
    logic [31:0]            in_data;
    wire                    in_read;
    wire                    out_valid;
    wire  [7:0]             out_data;
    logic                   out_ready;
    wire  [SRAM_ADDR_W-1:0] sram_a;
    wire  [SRAM_DATA_W-1:0] sram_dq;
    wire                    sram_we_b;
    wire                    sram_oe_b;
    wire                    near_full;
    wire                    fifo_full;
    wire                    fifo_not_empty;
    wire                    fifo_read_error;

    logic [31:0]    send_q[$];
    logic [7:0]     exp_q[$];
    logic           drain;
    logic           poke_ready;
    logic           mon_en;
    logic           nf_exp;
    int             prev_level;
    int             err_cnt;
    int             check_cnt;
    int             fail_total;
    integer         seed;
    string          test_name;

    sram_fifo_top #(.DEPTH(DEPTH)) i_dut (.*);
    sram_model i_sram (.*);
    bind sram_ctrl sram_ctrl_props #(.DEPTH(DEPTH)) i_props (.*);

    initial begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired before the tests completed");
        $display("Test failed");
        $finish;
    end

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    // one clock with producer and consumer acting on the falling edge
    task automatic step();
        int b;
        @(negedge BUS_CLK);
        if (prev_level >= NF_SET) begin
            nf_exp = 1'b1;
        end else if (prev_level <= NF_CLR) begin  // otherwise the flag holds
            nf_exp = 1'b0;
        end
        if (mon_en) begin
            expect_eq("near_full", nf_exp, near_full);
        end
        prev_level = int'(i_dut.level);  // flag follows level one cycle later
        if (in_read && send_q.size() != 0) begin
            in_data  = send_q.pop_front();
            in_empty = 1'b0;
            for (b = 0; b < 4; b++) begin
                exp_q.push_back(in_data[8*b +: 8]);  // low byte first
            end
        end else begin
            in_empty = 1'b1;
        end
        if (drain && out_valid) begin
            out_ready = 1'b1;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("[ERROR] %s: a byte came out with no byte expected", test_name);
            end else begin
                expect_eq("out_data", exp_q.pop_front(), out_data);
            end
        end else begin
            out_ready = poke_ready;
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
        step();
        {psel, pwrite, penable, paddr, pwdata} = {3'b110, addr, data};
        step();
        penable = 1'b1;
        step();
        {psel, pwrite, penable} = 3'b000;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [7:0] data);
        step();
        {psel, pwrite, penable, paddr} = {3'b100, addr};
        step();
        penable = 1'b1;
        data = prdata;  // steady through the access phase
        step();
        {psel, penable} = 2'b00;
    endtask

    task automatic queue_words(input int n);
        repeat (n) send_q.push_back($random(seed));
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 6) begin
            step();
            quiet = (send_q.size() == 0 && sram_we_b && sram_oe_b) ? quiet + 1 : 0;
        end
    endtask

    task automatic drain_all();
        drain = 1'b1;
        while (exp_q.size() != 0) step();
        repeat (4) step();  // room for a surplus byte to show
        drain = 1'b0;
    endtask

    task automatic check_defaults();
        logic [7:0] rd;
        apb_read(REG_CTRL, rd);
        expect_eq("REG_CTRL", 2, rd);
        apb_read(REG_AF, rd);
        expect_eq("REG_AF", AF_EXP, rd);
        apb_read(REG_AE, rd);
        expect_eq("REG_AE", AE_EXP, rd);
        apb_read(REG_ERR, rd);
        expect_eq("REG_ERR", 0, rd);
        expect_eq("fifo_read_error", 0, fifo_read_error);
    endtask

    task automatic test_registers();
        logic [7:0] rd;
        test_name = "registers";
        expect_eq("out_valid", 0, out_valid);
        expect_eq("sram_we_b", 1, sram_we_b);
        expect_eq("sram_oe_b", 1, sram_oe_b);
        expect_eq("near_full", 0, near_full);
        check_defaults();
        apb_write(REG_AF, 8'h5a);
        apb_read(REG_AF, rd);
        expect_eq("REG_AF readback", 8'h5a, rd);
        apb_write(REG_AF, AF_EXP);
    endtask

    task automatic test_data_order();
        test_name = "data order";
        drain = 1'b1;
        queue_words(20);
        while (send_q.size() != 0) step();
        drain_all();
        expect_eq("fifo_not_empty", 0, fifo_not_empty);
    endtask

    task automatic test_size();
        logic [7:0] s0;
        logic [7:0] s1;
        logic [7:0] s2;
        test_name = "size";
        queue_words(10);
        wait_idle();
        expect_eq("fifo_not_empty", 1, fifo_not_empty);
        expect_eq("fifo_full", 0, fifo_full);
        apb_read(REG_SIZE0, s0);
        apb_read(REG_SIZE1, s1);
        apb_read(REG_SIZE2, s2);
        expect_eq("size in bytes", 4 * 10, {s2, s1, s0});
        drain_all();
    endtask

    task automatic test_full();
        int stall;
        test_name = "full";
        stall = 0;
        mon_en = 1'b1;
        queue_words(40);
        while (stall < 8) begin
            step();
            stall = in_read ? 0 : stall + 1;
        end
        expect_eq("fifo_full", 1, fifo_full);
        expect_eq("near_full", 1, near_full);
        send_q.delete();  // words the fifo never took
        drain_all();
        expect_eq("near_full after drain", 0, near_full);
        expect_eq("fifo_full after drain", 0, fifo_full);
        expect_eq("fifo_not_empty", 0, fifo_not_empty);
        mon_en = 1'b0;
    endtask

    task automatic test_soft_reset();
        logic [7:0] rd;
        test_name = "soft reset";
        poke_ready = 1'b1;
        repeat (3) step();
        poke_ready = 1'b0;
        apb_read(REG_ERR, rd);
        expect_eq("REG_ERR", 3, rd);
        expect_eq("fifo_read_error", 1, fifo_read_error);
        apb_write(REG_AF, 8'd100);
        apb_write(REG_AE, 8'd50);
        apb_write(REG_CTRL, 8'd0);
        check_defaults();
    endtask

    initial begin
        seed = 32'h39ae361f;
        {RST, psel, penable, pwrite, paddr, pwdata} = {4'b1000, 4'd0, 8'd0};
        {in_empty, in_data, out_ready} = {1'b1, 32'd0, 1'b0};
        {drain, poke_ready, mon_en, nf_exp} = 4'b0000;
        {prev_level, err_cnt, check_cnt} = {32'd0, 32'd0, 32'd0};
        test_name = "reset";
        repeat (10) @(negedge BUS_CLK);
        RST = 1'b0;
        test_registers();
        test_data_order();
        test_size();
        test_full();
        test_soft_reset();
        fail_total = err_cnt + i_dut.i_ctrl.i_props.fail_cnt;
        $display("checks %0d, check errors %0d, assertion failures %0d",
                 check_cnt, err_cnt, i_dut.i_ctrl.i_props.fail_cnt);
        if (fail_total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/sram_fifo_pkg.sv
hw/sram_fifo_regs.sv
hw/word_buffer.sv
hw/sram_ctrl.sv
hw/fill_monitor.sv
hw/sram_fifo_top.sv
verification/sram_model.sv
verification/sram_ctrl_props.sv
verification/tb_sram_fifo.sv

/* Bender.yml */
package:
  name: sram_fifo

sources:
  - hw/sram_fifo_pkg.sv
  - hw/sram_fifo_regs.sv
  - hw/word_buffer.sv
  - hw/sram_ctrl.sv
  - hw/fill_monitor.sv
  - hw/sram_fifo_top.sv
  - target: simulation
    files:
      - verification/sram_model.sv
      - verification/sram_ctrl_props.sv
      - verification/tb_sram_fifo.sv
